// File: hdl/exe_alu.sv
`timescale 1ns/1ps
`include "exe_defs.svh"

module exe_alu
    import exe_pkg::*;
(
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  alu_op_e          alu_op,
    input  logic             op_32,
    output logic [`XLEN-1:0] alu_result
);

    localparam int EXT_W = `XLEN - `WORD_W;

    logic [5:0]         shamt_d;
    logic [4:0]         shamt_w;
    logic [`WORD_W-1:0] add_w;
    logic [`WORD_W-1:0] sub_w;
    logic [`WORD_W-1:0] sll_w;
    logic [`WORD_W-1:0] srl_w;
    logic [`WORD_W-1:0] sra_w;

    function automatic logic [`XLEN-1:0] sext_word(input logic [`WORD_W-1:0] w);
        sext_word = {{EXT_W{w[`WORD_W-1]}}, w};
    endfunction

    assign shamt_d = a[5:0];
    assign shamt_w = a[4:0];

    ////////////////////////////////////////////////////////////
    // Word mode results, b is the first operand
    ////////////////////////////////////////////////////////////

    assign add_w = b[`WORD_W-1:0] + a[`WORD_W-1:0];
    assign sub_w = b[`WORD_W-1:0] - a[`WORD_W-1:0];
    assign sll_w = b[`WORD_W-1:0] << shamt_w;
    assign srl_w = b[`WORD_W-1:0] >> shamt_w;
    assign sra_w = $signed(b[`WORD_W-1:0]) >>> shamt_w;

    ////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (alu_op)
            alu_add:     alu_result = op_32 ? sext_word(add_w) : b + a;
            alu_sub:     alu_result = op_32 ? sext_word(sub_w) : b - a;
            alu_sll:     alu_result = op_32 ? sext_word(sll_w) : b << shamt_d;
            alu_srl:     alu_result = op_32 ? sext_word(srl_w) : b >> shamt_d;
            // Arithmetic shift kept signed inside its own operand
            alu_sra:     alu_result = op_32 ? sext_word(sra_w)
                                            : $unsigned($signed(b) >>> shamt_d);
            alu_xor:     alu_result = a ^ b;
            alu_or:      alu_result = a | b;
            alu_and:     alu_result = a & b;
            alu_slt:     alu_result = {{(`XLEN-1){1'b0}}, $signed(b) < $signed(a)};
            alu_sltu:    alu_result = {{(`XLEN-1){1'b0}}, b < a};
            alu_pass_a:  alu_result = a;
            alu_pass_b:  alu_result = b;
            // Link address for jumps
            alu_b_plus4: alu_result = b + `XLEN'(`INSN_BYTES);
            default:     alu_result = '0;
        endcase
    end

    // Codes 14 and 15 have no operation behind them
    alu_op_legal: assert final ($isunknown(alu_op) || alu_op inside {[alu_add:alu_idle]})
        else $error("exe_alu: undefined alu_op %0d", alu_op);

endmodule

// File: hdl/exe_branch_unit.sv
`timescale 1ns/1ps
`include "exe_defs.svh"

module exe_branch_unit
    import exe_pkg::*;
(
    input  logic [`XLEN-1:0] comp1,
    input  logic [`XLEN-1:0] comp2,
    input  branch_cond_e     branch_cond,
    input  logic             cbranch,
    input  logic             jump,
    input  logic             jumpr,
    input  logic [`XLEN-1:0] jump_base,
    input  logic [`XLEN-1:0] jump_offset,
    output logic             branch_taken,
    output logic [`XLEN-1:0] jump_addr
);

    logic equal;
    logic less_s;
    logic less_u;
    logic cond_true;

    // One comparator pair serves both signed and unsigned forms
    assign equal  = comp1 == comp2;
    assign less_s = $signed(comp1) < $signed(comp2);
    assign less_u = comp1 < comp2;

    always_comb
    begin
        case (branch_cond)
            br_beq:  cond_true = equal;
            br_bne:  cond_true = !equal;
            br_blt:  cond_true = less_s;
            br_bge:  cond_true = !less_s;
            br_bltu: cond_true = less_u;
            br_bgeu: cond_true = !less_u;
            default: cond_true = 1'b0;
        endcase
    end

    assign branch_taken = cbranch ? cond_true : (jump || jumpr);

    // Base is pc for jal and branches, rs1 for jalr
    assign jump_addr = jump_base + jump_offset;

endmodule

// File: hdl/exe_mem_check.sv
`timescale 1ns/1ps
`include "exe_defs.svh"

module exe_mem_check
    import exe_pkg::*;
(
    input  logic [`XLEN-1:0] addr,
    input  mem_access_e      mem_access,
    input  ldst_size_e       ldst_size,
    input  logic             kill,
    output mem_access_e      mem_access_out,
    output logic             load_misaligned,
    output logic             store_misaligned,
    output logic             load_word
);

    logic [2:0] offset;
    logic       crosses;

    assign offset = addr[2:0];

    ////////////////////////////////////////////////////////////
    // Only accesses spilling past an 8-byte line are flagged
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (ldst_size)
            sz_half,
            sz_uhalf:  crosses = &offset;
            sz_word,
            sz_uword:  crosses = offset > 3'd4;
            sz_double: crosses = |offset;
            default:   crosses = 1'b0;
        endcase
    end

    assign load_misaligned  = crosses && (mem_access == mem_load);
    assign store_misaligned = crosses && (mem_access == mem_store);

    // Narrower loads go through the word path
    assign load_word = ldst_size != sz_double;

    // No request leaves while the stage is killed
    assign mem_access_out = kill ? mem_none : mem_access;

    one_misalign_kind: assert final (!(load_misaligned && store_misaligned))
        else $error("exe_mem_check: load and store misalignment together");

endmodule

// File: hdl/exe_pkg.sv
package exe_pkg;

    // ALU result select
    typedef enum logic [3:0] {
        alu_add     = 4'd0,
        alu_sub     = 4'd1,
        alu_sll     = 4'd2,
        alu_srl     = 4'd3,
        alu_sra     = 4'd4,
        alu_xor     = 4'd5,
        alu_or      = 4'd6,
        alu_and     = 4'd7,
        alu_slt     = 4'd8,
        alu_sltu    = 4'd9,
        alu_pass_a  = 4'd10,
        alu_pass_b  = 4'd11,
        alu_b_plus4 = 4'd12,
        alu_idle    = 4'd13
    } alu_op_e;

    // Branch funct3, codes 2 and 3 never taken
    typedef enum logic [2:0] {
        br_beq  = 3'd0,
        br_bne  = 3'd1,
        br_blt  = 3'd4,
        br_bge  = 3'd5,
        br_bltu = 3'd6,
        br_bgeu = 3'd7
    } branch_cond_e;

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_access_e;

    // Access size, same order as load funct3
    typedef enum logic [2:0] {
        sz_byte   = 3'd0,
        sz_half   = 3'd1,
        sz_word   = 3'd2,
        sz_double = 3'd3,
        sz_ubyte  = 3'd4,
        sz_uhalf  = 3'd5,
        sz_uword  = 3'd6
    } ldst_size_e;

endpackage

// File: hdl/exe_redirect_ctrl.sv
`timescale 1ns/1ps
`include "exe_defs.svh"

module exe_redirect_ctrl (
    input  logic             CLK,
    input  logic             RST,
    input  logic             cache_ready,
    input  logic             branch_taken,
    input  logic [`XLEN-1:0] jump_addr,
    input  logic [`XLEN-1:0] pc_id,
    input  logic [`XLEN-1:0] pc_ex,
    input  logic             seq_check,
    output logic             jump_final,
    output logic             flush,
    output logic             kill,
    output logic             predicted
);

    localparam int               CNT_W      = $clog2(`KILL_HOLD + 1);
    localparam logic [CNT_W-1:0] FLUSH_LAST = CNT_W'(`FLUSH_HOLD - 1);
    localparam logic [CNT_W-1:0] KILL_LAST  = CNT_W'(`KILL_HOLD - 1);

    logic [`XLEN-1:0] seq_pc;
    logic             jump_miss;
    logic             seq_miss;
    logic             seq_resolve;
    logic [CNT_W-1:0] flush_cnt;
    logic [CNT_W-1:0] kill_cnt;

    assign seq_pc      = pc_ex + `XLEN'(`INSN_BYTES);
    assign jump_miss   = pc_id != jump_addr;
    assign seq_miss    = pc_id != seq_pc;
    assign seq_resolve = seq_check && !kill;
    assign jump_final  = branch_taken && !kill;

    ////////////////////////////////////////////////////////////
    // Flush and kill windows, frozen while the cache is busy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            flush     <= 1'b0;
            kill      <= 1'b0;
            flush_cnt <= '0;
            kill_cnt  <= '0;
        end
        else if (cache_ready)
        begin
            if (jump_final)
            begin
                flush <= jump_miss;
                kill  <= jump_miss;
            end
            else if (seq_resolve)
            begin
                flush <= seq_miss;
                kill  <= seq_miss;
            end
            else
            begin
                if (flush_cnt == FLUSH_LAST)
                    flush <= 1'b0;
                if (kill_cnt == KILL_LAST)
                    kill <= 1'b0;
            end
            flush_cnt <= flush ? flush_cnt + 1'b1 : '0;
            kill_cnt  <= kill ? kill_cnt + 1'b1 : '0;
        end
    end

    always_comb
    begin
        if (cache_ready && jump_final)
            predicted = !jump_miss;
        else if (cache_ready && seq_resolve)
            predicted = !seq_miss;
        else
            predicted = 1'b1;
    end

    flush_within_kill: assert property (@(posedge CLK) disable iff (RST) flush |-> kill);

    // Kill outlasts flush, so flush is already gone when kill drops
    kill_after_flush: assert property (@(posedge CLK) disable iff (RST)
        $fell(kill) |-> !$past(flush));

endmodule

// File: hdl/exe_stage.sv
`timescale 1ns/1ps
`include "exe_defs.svh"

module exe_stage
    import exe_pkg::*;
(
    input  logic             CLK,
    input  logic             RST,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  alu_op_e          alu_op,
    input  logic             op_32,
    input  logic [`XLEN-1:0] comp1,
    input  logic [`XLEN-1:0] comp2,
    input  branch_cond_e     branch_cond,
    input  logic             cbranch,
    input  logic             jump,
    input  logic             jumpr,
    input  logic [`XLEN-1:0] jump_base,
    input  logic [`XLEN-1:0] jump_offset,
    input  logic [`XLEN-1:0] pc_ex,
    input  logic [`XLEN-1:0] pc_id,
    input  logic             seq_check,
    input  mem_access_e      mem_access,
    input  ldst_size_e       ldst_size,
    input  logic             cache_ready,
    output logic [`XLEN-1:0] wb_data,
    output logic             jump_final,
    output logic [`XLEN-1:0] jump_addr,
    output logic             flush,
    output logic             kill,
    output logic             predicted,
    output mem_access_e      mem_access_out,
    output logic             load_misaligned,
    output logic             store_misaligned,
    output logic             load_word
);

    logic branch_taken;

    exe_branch_unit branch_unit_inst (
        .comp1        (comp1),
        .comp2        (comp2),
        .branch_cond  (branch_cond),
        .cbranch      (cbranch),
        .jump         (jump),
        .jumpr        (jumpr),
        .jump_base    (jump_base),
        .jump_offset  (jump_offset),
        .branch_taken (branch_taken),
        .jump_addr    (jump_addr)
    );

    exe_alu alu_inst (
        .a          (a),
        .b          (b),
        .alu_op     (alu_op),
        .op_32      (op_32),
        .alu_result (wb_data)
    );

    exe_redirect_ctrl redirect_inst (
        .CLK          (CLK),
        .RST          (RST),
        .cache_ready  (cache_ready),
        .branch_taken (branch_taken),
        .jump_addr    (jump_addr),
        .pc_id        (pc_id),
        .pc_ex        (pc_ex),
        .seq_check    (seq_check),
        .jump_final   (jump_final),
        .flush        (flush),
        .kill         (kill),
        .predicted    (predicted)
    );

    // ALU result doubles as the data address
    exe_mem_check mem_check_inst (
        .addr             (wb_data),
        .mem_access       (mem_access),
        .ldst_size        (ldst_size),
        .kill             (kill),
        .mem_access_out   (mem_access_out),
        .load_misaligned  (load_misaligned),
        .store_misaligned (store_misaligned),
        .load_word        (load_word)
    );

endmodule

// File: include/exe_defs.svh
`ifndef EXE_DEFS_SVH
`define EXE_DEFS_SVH

////////////////////////////////////////////////////////////
// Datapath widths
////////////////////////////////////////////////////////////

`define XLEN        64
`define WORD_W      32

// Sequential PC step
`define INSN_BYTES  4

////////////////////////////////////////////////////////////
// Redirect hold lengths, in cache ready cycles
////////////////////////////////////////////////////////////

`define FLUSH_HOLD  4
`define KILL_HOLD   6

`endif

// File: src.f
+incdir+include
hdl/exe_pkg.sv
hdl/exe_alu.sv
hdl/exe_branch_unit.sv
hdl/exe_redirect_ctrl.sv
hdl/exe_mem_check.sv
hdl/exe_stage.sv
testbench/exe_checker.sv
testbench/tb_exe_stage.sv

// File: testbench/exe_checker.sv
`timescale 1ns/1ps
`include "exe_defs.svh"

module exe_checker
    import exe_pkg::*;
(
    input  logic             CLK,
    input  logic             RST,
    input  logic             done,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  alu_op_e          alu_op,
    input  logic             op_32,
    input  logic [`XLEN-1:0] comp1,
    input  logic [`XLEN-1:0] comp2,
    input  branch_cond_e     branch_cond,
    input  logic             cbranch,
    input  logic             jump,
    input  logic             jumpr,
    input  logic [`XLEN-1:0] jump_base,
    input  logic [`XLEN-1:0] jump_offset,
    input  logic [`XLEN-1:0] pc_ex,
    input  logic [`XLEN-1:0] pc_id,
    input  logic             seq_check,
    input  mem_access_e      mem_access,
    input  ldst_size_e       ldst_size,
    input  logic             cache_ready,
    input  logic [`XLEN-1:0] wb_data,
    input  logic             jump_final,
    input  logic [`XLEN-1:0] jump_addr,
    input  logic             flush,
    input  logic             kill,
    input  logic             predicted,
    input  mem_access_e      mem_access_out,
    input  logic             load_misaligned,
    input  logic             store_misaligned,
    input  logic             load_word,
    output int               failed_tests
);

    localparam int T_ALU = 0;
    localparam int T_BR  = 1;
    localparam int T_MEM = 2;
    localparam int T_RED = 3;
    localparam int T_BP  = 4;
    localparam int NUM_TESTS = 5;

    int checks [NUM_TESTS];
    int errors [NUM_TESTS];

    // Reference redirect state
    logic             m_flush;
    logic             m_kill;
    int               flush_held;
    int               kill_held;
    logic             stall_seen;
    logic             next_flush;
    logic             next_kill;
    logic [`XLEN-1:0] alu_exp;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] seq_next;
    logic             jf_exp;
    logic             pred_exp;
    logic             cross_exp;
    int               state_test;

    initial
    begin
        for (int t = 0; t < NUM_TESTS; t++)
        begin
            checks[t] = 0;
            errors[t] = 0;
        end
    end

    function automatic string test_name(input int t);
        case (t)
            T_ALU:   return "alu_ops";
            T_BR:    return "branch_resolve";
            T_MEM:   return "mem_misalign";
            T_RED:   return "redirect_flush";
            default: return "backpressure";
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Reference functions
    ////////////////////////////////////////////////////////////

    function automatic logic [`XLEN-1:0] alu_result_of(
        input logic [`XLEN-1:0] x,
        input logic [`XLEN-1:0] y,
        input alu_op_e          op,
        input logic             word
    );
        logic [5:0]               sh;
        logic signed [`XLEN-1:0]  ys;
        logic [`XLEN-1:0]         yz;
        logic [`XLEN-1:0]         r;
        sh = word ? {1'b0, x[4:0]} : x[5:0];
        // Word shifts only see the low word of b
        ys = word ? {{(`XLEN-`WORD_W){y[`WORD_W-1]}}, y[`WORD_W-1:0]} : y;
        yz = word ? {{(`XLEN-`WORD_W){1'b0}}, y[`WORD_W-1:0]} : y;
        case (op)
            alu_add:     r = y + x;
            alu_sub:     r = y - x;
            alu_sll:     r = y << sh;
            alu_srl:     r = yz >> sh;
            alu_sra:     r = ys >>> sh;
            alu_xor:     r = x ^ y;
            alu_or:      r = x | y;
            alu_and:     r = x & y;
            alu_slt:     r = ($signed(y) < $signed(x)) ? 64'd1 : 64'd0;
            alu_sltu:    r = (y < x) ? 64'd1 : 64'd0;
            alu_pass_a:  r = x;
            alu_pass_b:  r = y;
            alu_b_plus4: r = y + 64'd4;
            default:     r = '0;
        endcase
        if (word && (op inside {alu_add, alu_sub, alu_sll, alu_srl, alu_sra}))
            r = {{(`XLEN-`WORD_W){r[`WORD_W-1]}}, r[`WORD_W-1:0]};
        return r;
    endfunction

    function automatic logic branch_taken_of(
        input logic [`XLEN-1:0] c1,
        input logic [`XLEN-1:0] c2,
        input branch_cond_e     cond,
        input logic             cb,
        input logic             j,
        input logic             jr
    );
        logic hit;
        case (cond)
            br_beq:  hit = c1 == c2;
            br_bne:  hit = c1 != c2;
            br_blt:  hit = $signed(c1) < $signed(c2);
            br_bge:  hit = $signed(c1) >= $signed(c2);
            br_bltu: hit = c1 < c2;
            br_bgeu: hit = c1 >= c2;
            default: hit = 1'b0;
        endcase
        return cb ? hit : (j || jr);
    endfunction

    // Access spills past an 8-byte boundary
    function automatic logic crosses_line(input logic [2:0] lo, input ldst_size_e size);
        case (size)
            sz_half,
            sz_uhalf:  return lo == 3'd7;
            sz_word,
            sz_uword:  return lo > 3'd4;
            sz_double: return lo != 3'd0;
            default:   return 1'b0;
        endcase
    endfunction

    task automatic check_value(
        input int               t,
        input string            what,
        input logic [`XLEN-1:0] exp,
        input logic [`XLEN-1:0] act
    );
        checks[t]++;
        if (act !== exp)
        begin
            errors[t]++;
            $display("Error: test %s, %s expected %0h actual %0h at %0t",
                     test_name(t), what, exp, act, $time);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Per-cycle comparison, inputs settled since the falling edge
    ////////////////////////////////////////////////////////////

    always @(posedge CLK)
    begin
        if (RST)
        begin
            m_flush    = 1'b0;
            m_kill     = 1'b0;
            flush_held = 0;
            kill_held  = 0;
            stall_seen = 1'b0;
        end
        else
        begin
            alu_exp = alu_result_of(a, b, alu_op, op_32);
            check_value(T_ALU, "wb_data", alu_exp, wb_data);

            target = jump_base + jump_offset;
            jf_exp = branch_taken_of(comp1, comp2, branch_cond, cbranch, jump, jumpr)
                     && !m_kill;
            check_value(T_BR, "jump_addr", target, jump_addr);
            check_value(T_BR, "jump_final", jf_exp, jump_final);

            cross_exp = crosses_line(alu_exp[2:0], ldst_size);
            check_value(T_MEM, "load_misaligned", cross_exp && mem_access == mem_load,
                        load_misaligned);
            check_value(T_MEM, "store_misaligned", cross_exp && mem_access == mem_store,
                        store_misaligned);
            check_value(T_MEM, "load_word", ldst_size != sz_double, load_word);
            check_value(T_MEM, "mem_access_out", m_kill ? mem_none : mem_access,
                        mem_access_out);

            seq_next = pc_ex + 64'd4;
            if (cache_ready && jf_exp)
                pred_exp = pc_id == target;
            else if (cache_ready && seq_check && !m_kill)
                pred_exp = pc_id == seq_next;
            else
                pred_exp = 1'b1;
            check_value(T_RED, "predicted", pred_exp, predicted);

            // Windows that went through a stall count as back-pressure
            state_test = stall_seen ? T_BP : T_RED;
            check_value(state_test, "flush", m_flush, flush);
            check_value(state_test, "kill", m_kill, kill);

            if (cache_ready)
            begin
                next_flush = m_flush;
                next_kill  = m_kill;
                if (jf_exp)
                begin
                    next_flush = pc_id != target;
                    next_kill  = pc_id != target;
                end
                else if (seq_check && !m_kill)
                begin
                    next_flush = pc_id != seq_next;
                    next_kill  = pc_id != seq_next;
                end
                else
                begin
                    if (m_flush && flush_held + 1 == `FLUSH_HOLD)
                        next_flush = 1'b0;
                    if (m_kill && kill_held + 1 == `KILL_HOLD)
                        next_kill = 1'b0;
                end
                flush_held = m_flush ? flush_held + 1 : 0;
                kill_held  = m_kill ? kill_held + 1 : 0;
                m_flush    = next_flush;
                m_kill     = next_kill;
            end

            if (!cache_ready && (m_flush || m_kill))
                stall_seen = 1'b1;
            else if (!m_flush && !m_kill)
                stall_seen = 1'b0;
        end
    end

    // A test with no checks at all is a failure too
    always @(posedge done)
    begin
        failed_tests = 0;
        for (int t = 0; t < NUM_TESTS; t++)
        begin
            if (errors[t] != 0 || checks[t] == 0)
                failed_tests++;
            $display("Test %s: %0d checks, %0d errors, %s", test_name(t), checks[t],
                     errors[t], (errors[t] == 0 && checks[t] > 0) ? "passed" : "failed");
        end
        $display("Tests passed: %0d, failed: %0d", NUM_TESTS - failed_tests, failed_tests);
    end

endmodule

// File: testbench/tb_exe_stage.sv
`timescale 1ns/1ps
`include "exe_defs.svh"

module tb_exe_stage
    import exe_pkg::*;
();

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 4;
    localparam int NUM_CYCLES   = 2000;
    localparam int MARGIN       = 20;

    logic             CLK;
    logic             RST;
    logic             done;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    alu_op_e          alu_op;
    logic             op_32;
    logic [`XLEN-1:0] comp1;
    logic [`XLEN-1:0] comp2;
    branch_cond_e     branch_cond;
    logic             cbranch;
    logic             jump;
    logic             jumpr;
    logic [`XLEN-1:0] jump_base;
    logic [`XLEN-1:0] jump_offset;
    logic [`XLEN-1:0] pc_ex;
    logic [`XLEN-1:0] pc_id;
    logic             seq_check;
    mem_access_e      mem_access;
    ldst_size_e       ldst_size;
    logic             cache_ready;
    logic [`XLEN-1:0] wb_data;
    logic             jump_final;
    logic [`XLEN-1:0] jump_addr;
    logic             flush;
    logic             kill;
    logic             predicted;
    mem_access_e      mem_access_out;
    logic             load_misaligned;
    logic             store_misaligned;
    logic             load_word;
    int               failed_tests;
    integer           seed;

    initial
    begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    function automatic logic [`XLEN-1:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic init_inputs();
        RST         = 1'b1;
        done        = 1'b0;
        a           = '0;
        b           = '0;
        alu_op      = alu_idle;
        op_32       = 1'b0;
        comp1       = '0;
        comp2       = '0;
        branch_cond = br_beq;
        cbranch     = 1'b0;
        jump        = 1'b0;
        jumpr       = 1'b0;
        jump_base   = '0;
        jump_offset = '0;
        pc_ex       = '0;
        pc_id       = '0;
        seq_check   = 1'b0;
        mem_access  = mem_none;
        ldst_size   = sz_byte;
        cache_ready = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // Random stimulus, one instruction per cycle
    ////////////////////////////////////////////////////////////

    task automatic drive_random_inputs();
        int pick;
        pick        = $unsigned($random(seed)) % 6;
        a           = rand64();
        b           = rand64();
        alu_op      = alu_op_e'(4'($unsigned($random(seed)) % 14));
        op_32       = 1'($random(seed));
        comp1       = rand64();
        comp2       = (($unsigned($random(seed)) % 4) == 0) ? comp1 : rand64();
        branch_cond = branch_cond_e'(3'($random(seed)));
        jump_base   = rand64();
        jump_offset = rand64();
        pc_ex       = rand64() & ~64'h3;
        cbranch     = 1'b0;
        jump        = 1'b0;
        jumpr       = 1'b0;
        // Control transfers are rare so windows get to expire
        if (pick == 0)
        begin
            case ($unsigned($random(seed)) % 3)
                0:       cbranch = 1'b1;
                1:       jump = 1'b1;
                default: jumpr = 1'b1;
            endcase
            seq_check = 1'b0;
        end
        else
            seq_check = ($unsigned($random(seed)) % 4) != 0;
        if (1'($random(seed)))
            pc_id = (pick == 0) ? jump_base + jump_offset : pc_ex + 64'd4;
        else
            pc_id = rand64();
        mem_access  = mem_access_e'(2'($unsigned($random(seed)) % 3));
        ldst_size   = ldst_size_e'(3'($unsigned($random(seed)) % 7));
        cache_ready = ($unsigned($random(seed)) % 8) != 0;
    endtask

    initial
    begin
        init_inputs();
        seed = 32'h9b83;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;
        drive_random_inputs();
        repeat (NUM_CYCLES - 1)
        begin
            @(negedge CLK);
            drive_random_inputs();
        end
        @(negedge CLK);
        done = 1'b1;
        #1;
        if (failed_tests == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        #((RESET_CYCLES + NUM_CYCLES + MARGIN) * PERIOD);
        $display("Timeout: the stimulus did not complete in %0d cycles",
                 RESET_CYCLES + NUM_CYCLES + MARGIN);
        $display("SOME TESTS FAILED");
        $finish;
    end

    exe_stage exe_stage_inst (
        .CLK              (CLK),
        .RST              (RST),
        .a                (a),
        .b                (b),
        .alu_op           (alu_op),
        .op_32            (op_32),
        .comp1            (comp1),
        .comp2            (comp2),
        .branch_cond      (branch_cond),
        .cbranch          (cbranch),
        .jump             (jump),
        .jumpr            (jumpr),
        .jump_base        (jump_base),
        .jump_offset      (jump_offset),
        .pc_ex            (pc_ex),
        .pc_id            (pc_id),
        .seq_check        (seq_check),
        .mem_access       (mem_access),
        .ldst_size        (ldst_size),
        .cache_ready      (cache_ready),
        .wb_data          (wb_data),
        .jump_final       (jump_final),
        .jump_addr        (jump_addr),
        .flush            (flush),
        .kill             (kill),
        .predicted        (predicted),
        .mem_access_out   (mem_access_out),
        .load_misaligned  (load_misaligned),
        .store_misaligned (store_misaligned),
        .load_word        (load_word)
    );

    exe_checker checker_inst (
        .CLK              (CLK),
        .RST              (RST),
        .done             (done),
        .a                (a),
        .b                (b),
        .alu_op           (alu_op),
        .op_32            (op_32),
        .comp1            (comp1),
        .comp2            (comp2),
        .branch_cond      (branch_cond),
        .cbranch          (cbranch),
        .jump             (jump),
        .jumpr            (jumpr),
        .jump_base        (jump_base),
        .jump_offset      (jump_offset),
        .pc_ex            (pc_ex),
        .pc_id            (pc_id),
        .seq_check        (seq_check),
        .mem_access       (mem_access),
        .ldst_size        (ldst_size),
        .cache_ready      (cache_ready),
        .wb_data          (wb_data),
        .jump_final       (jump_final),
        .jump_addr        (jump_addr),
        .flush            (flush),
        .kill             (kill),
        .predicted        (predicted),
        .mem_access_out   (mem_access_out),
        .load_misaligned  (load_misaligned),
        .store_misaligned (store_misaligned),
        .load_word        (load_word),
        .failed_tests     (failed_tests)
    );

endmodule
